// File: sim/vec_trace.txt
// Columns in hex: opcode vd vs1 vs2 vl scalar expected_result expected_error
// Opcode ffffffff ends the trace; VREAD reads register vs1 at index scalar
// Index and splat over the full length
7 1 0 0 10 00000000 00000000 0
6 2 0 0 10 fffffff8 00000000 0
8 0 1 0 0 00000000 00000000 0
8 0 1 0 0 00000007 00000007 0
8 0 1 0 0 0000000f 0000000f 0
8 0 2 0 0 00000003 fffffff8 0
// Element-wise arithmetic, v3 = i - 8 wraps below 8
0 3 1 2 10 00000000 00000000 0
8 0 3 0 0 00000009 00000001 0
8 0 3 0 0 00000002 fffffffa 0
1 4 1 2 10 00000000 00000000 0
8 0 4 0 0 00000005 0000000d 0
2 5 1 3 10 00000000 00000000 0
8 0 5 0 0 0000000a 00000002 0
8 0 5 0 0 00000006 00000006 0
3 6 1 2 10 00000000 00000000 0
8 0 6 0 0 0000000c fffffffc 0
4 7 2 1 10 00000000 00000000 0
8 0 7 0 0 0000000d fffffff5 0
5 0 2 0 10 0000000c 00000000 0
8 0 0 0 0 0000000b 00000004 0
// Tail undisturbed, then vl 0 writes nothing
6 1 0 0 5 0000abcd 00000000 0
8 0 1 0 0 00000004 0000abcd 0
8 0 1 0 0 00000005 00000005 0
6 1 0 0 0 00001234 00000000 0
8 0 1 0 0 00000000 0000abcd 0
// Error responses leave the registers alone
9 1 0 0 10 00005555 00000000 1
f 1 1 1 10 00000000 00000000 1
6 1 0 0 11 0000dead 00000000 1
6 1 0 0 1f 0000beef 00000000 1
8 0 1 0 0 00000010 00000000 1
8 0 1 0 0 00000001 0000abcd 0
8 0 1 0 0 00000006 00000006 0
// Back-to-back reads
8 0 3 0 0 0000000f 00000007 0
8 0 4 0 0 00000000 00000008 0
8 0 6 0 0 00000003 fffffffb 0
8 0 7 0 0 00000008 fffffff0 0
ffffffff 0 0 0 0 00000000 00000000 0

// File: verilog.f
+incdir+hdl
hdl/vec_pkg.sv
hdl/vec_skid_buffer.sv
hdl/vec_dispatcher.sv
hdl/vec_sequencer.sv
hdl/vec_lane.sv
hdl/vec_top.sv
sim/tb_vec_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_vec_top
FILELIST  := verilog.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_vec_top.sv
// Trace-driven testbench for vec_top with clock, reset, driver, response checker and watchdog
`timescale 1ns/100ps

module tb_vec_top;

  import vec_pkg::*;

  localparam int          CLK_PERIOD      = 4;
  localparam int          RESET_CYCLES    = 8;
  localparam int          MAX_LINES       = 64;
  localparam int          NR_COLS         = 8;
  localparam int          CYCLES_PER_LINE = 40;
  localparam logic [31:0] END_MARKER      = 32'hffffffff;
  localparam logic [31:0] STALL_SEED      = 32'h0c70dac3;

  logic        clk_i;
  logic        reset_i;
  acc_req_t    acc_req_i;
  logic        acc_req_valid_i;
  logic        acc_req_ready_o;
  acc_resp_t   acc_resp_o;
  logic        acc_resp_valid_o;
  logic        acc_resp_ready_i;

  // Eight hex columns per trace line
  logic [31:0] trace_mem [MAX_LINES*NR_COLS];
  int          nr_lines;
  int          nr_checked;
  int          nr_errors;
  int          nr_tests;
  int          nr_failed_tests;

  vec_top i_dut (
    .clk_i            (clk_i           ),
    .reset_i          (reset_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helper tasks
  ////////////////////////////////////////////////////////////

  task automatic report_test(input string name, input bit failed);
    nr_tests++;
    if (failed) nr_failed_tests++;
    $display("test %s: %s", name, failed ? "failed" : "passed");
  endtask

  // End marker in the opcode column closes the trace
  task automatic count_trace_lines();
    nr_lines = -1;
    for (int t = 0; t < MAX_LINES; t++) begin
      if (nr_lines < 0 && trace_mem[t*NR_COLS] == END_MARKER) nr_lines = t;
    end
    if (nr_lines < 0) begin
      $display("trace file has no end marker within %0d lines", MAX_LINES);
      nr_errors++;
      nr_lines = 0;
    end
  endtask

  task automatic check_reset_state();
    int errs_before;
    errs_before = nr_errors;
    @(negedge clk_i);
    if (acc_resp_valid_o !== 1'b0) begin
      $display("CHECK FAILED: acc_resp_valid_o got %h expected %h", acc_resp_valid_o, 1'b0);
      nr_errors++;
    end
    if (acc_req_ready_o !== 1'b1) begin
      $display("CHECK FAILED: acc_req_ready_o got %h expected %h", acc_req_ready_o, 1'b1);
      nr_errors++;
    end
    report_test("reset state", nr_errors != errs_before);
    @(posedge clk_i);
    #0.5;
  endtask

  // Holds each request until the DUT takes it
  task automatic drive_requests();
    int base;
    bit accepted;
    for (int t = 0; t < nr_lines; t++) begin
      base             = t * NR_COLS;
      acc_req_i.op     = trace_mem[base][3:0];
      acc_req_i.vd     = trace_mem[base+1][2:0];
      acc_req_i.vs1    = trace_mem[base+2][2:0];
      acc_req_i.vs2    = trace_mem[base+3][2:0];
      acc_req_i.vl     = trace_mem[base+4][4:0];
      acc_req_i.scalar = trace_mem[base+5];
      acc_req_valid_i  = 1'b1;
      accepted         = 1'b0;
      while (!accepted) begin
        @(negedge clk_i);
        accepted = acc_req_ready_o;
        @(posedge clk_i);
      end
      #0.5;
    end
    acc_req_valid_i = 1'b0;
  endtask

  // Responses come back in request order
  task automatic check_responses();
    int          base;
    int          errs_before;
    logic [31:0] exp_result;
    logic        exp_error;
    while (nr_checked < nr_lines) begin
      @(negedge clk_i);
      if (acc_resp_valid_o && acc_resp_ready_i) begin
        base        = nr_checked * NR_COLS;
        exp_result  = trace_mem[base+6];
        exp_error   = trace_mem[base+7][0];
        errs_before = nr_errors;
        if (acc_resp_o.result !== exp_result) begin
          $display("CHECK FAILED: test %0d acc_resp_o.result got %h expected %h",
                   nr_checked + 1, acc_resp_o.result, exp_result);
          nr_errors++;
        end
        if (acc_resp_o.error !== exp_error) begin
          $display("CHECK FAILED: test %0d acc_resp_o.error got %h expected %h",
                   nr_checked + 1, acc_resp_o.error, exp_error);
          nr_errors++;
        end
        report_test($sformatf("%0d op %h", nr_checked + 1, trace_mem[base][3:0]),
                    nr_errors != errs_before);
        nr_checked++;
      end
    end
  endtask

  task automatic check_no_extra_response();
    bit seen;
    seen = 1'b0;
    repeat (20) begin
      @(negedge clk_i);
      if (acc_resp_valid_o) seen = 1'b1;
    end
    if (seen) begin
      $display("a response arrived after the last expected one");
      nr_errors++;
    end
    report_test("no extra response", seen);
  endtask

  ////////////////////////////////////////////////////////////
  // Processes
  ////////////////////////////////////////////////////////////

  // Random response stalls
  initial begin
    acc_resp_ready_i = 1'b0;
    void'($urandom(STALL_SEED));
    forever begin
      @(posedge clk_i);
      #0.5;
      acc_resp_ready_i = (($urandom % 100) < 32'd40);
    end
  end

  initial begin : main
    acc_req_i       = '0;
    acc_req_valid_i = 1'b0;
    reset_i         = 1'b1;
    nr_checked      = 0;
    nr_errors       = 0;
    nr_tests        = 0;
    nr_failed_tests = 0;
    $readmemh("sim/vec_trace.txt", trace_mem);
    count_trace_lines();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #0.5;
    reset_i = 1'b0;
    check_reset_state();
    fork
      drive_requests();
      check_responses();
    join
    check_no_extra_response();
    $display("summary: %0d tests, %0d failed, %0d check errors",
             nr_tests, nr_failed_tests, nr_errors);
    if (nr_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Limit scales with the trace length
  initial begin : watchdog
    int limit;
    @(posedge clk_i);
    limit = (nr_lines + 1) * CYCLES_PER_LINE + RESET_CYCLES;
    repeat (limit) @(posedge clk_i);
    $display("watchdog: run did not finish within %0d cycles, %0d of %0d responses seen",
             limit, nr_checked, nr_lines);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: hdl/vec_top.sv
// Top level with dispatcher, instruction and response buffers, sequencer and lanes
`timescale 1ns/100ps
`include "vec_cfg.svh"

module vec_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);

  import vec_pkg::*;

  localparam int unsigned NR_LANES = `VEC_NR_LANES;

  vinsn_t                     disp_vinsn;
  logic                       disp_vinsn_valid;
  logic                       disp_vinsn_ready;
  vinsn_t                     seq_vinsn;
  logic                       seq_vinsn_valid;
  logic                       seq_vinsn_ready;
  vinsn_t                     lane_vinsn;
  logic                       lane_start;
  logic  [NR_LANES-1:0]       lane_done;
  elen_t [NR_LANES-1:0]       lane_rdata;
  acc_resp_t                  seq_resp;
  logic                       seq_resp_valid;
  logic                       seq_resp_ready;

  ////////////////////////////////////////////////////////////
  // Front end
  ////////////////////////////////////////////////////////////

  vec_dispatcher i_dispatcher (
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .vinsn_o         (disp_vinsn      ),
    .vinsn_valid_o   (disp_vinsn_valid),
    .vinsn_ready_i   (disp_vinsn_ready)
  );

  vec_skid_buffer #(.payload_t(vinsn_t)) i_vinsn_buffer (
    .clk_i       (clk_i           ),
    .reset_i     (reset_i         ),
    .in_data_i   (disp_vinsn      ),
    .in_valid_i  (disp_vinsn_valid),
    .in_ready_o  (disp_vinsn_ready),
    .out_data_o  (seq_vinsn       ),
    .out_valid_o (seq_vinsn_valid ),
    .out_ready_i (seq_vinsn_ready )
  );

  ////////////////////////////////////////////////////////////
  // Sequencer and lanes
  ////////////////////////////////////////////////////////////

  vec_sequencer i_sequencer (
    .clk_i         (clk_i          ),
    .reset_i       (reset_i        ),
    .vinsn_i       (seq_vinsn      ),
    .vinsn_valid_i (seq_vinsn_valid),
    .vinsn_ready_o (seq_vinsn_ready),
    .lane_vinsn_o  (lane_vinsn     ),
    .lane_start_o  (lane_start     ),
    .lane_done_i   (lane_done      ),
    .lane_rdata_i  (lane_rdata     ),
    .resp_o        (seq_resp       ),
    .resp_valid_o  (seq_resp_valid ),
    .resp_ready_i  (seq_resp_ready )
  );

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    vec_lane #(.LANE_ID(l)) i_lane (
      .clk_i   (clk_i        ),
      .reset_i (reset_i      ),
      .vinsn_i (lane_vinsn   ),
      .start_i (lane_start   ),
      .done_o  (lane_done[l] ),
      .rdata_o (lane_rdata[l])
    );
  end

  vec_skid_buffer #(.payload_t(acc_resp_t)) i_resp_buffer (
    .clk_i       (clk_i           ),
    .reset_i     (reset_i         ),
    .in_data_i   (seq_resp        ),
    .in_valid_i  (seq_resp_valid  ),
    .in_ready_o  (seq_resp_ready  ),
    .out_data_o  (acc_resp_o      ),
    .out_valid_o (acc_resp_valid_o),
    .out_ready_i (acc_resp_ready_i)
  );

  // Elaboration checks on the lane split
  if (NR_LANES != 2 ** $clog2(NR_LANES)) begin : gen_check_pow2
    $error("vec_top: lane count must be a power of two");
  end
  if ((`VEC_VLMAX % NR_LANES) != 0) begin : gen_check_split
    $error("vec_top: lane count must divide VLMAX");
  end

endmodule

// File: hdl/vec_lane.sv
// Vector lane with its register file slice and element ALU
`timescale 1ns/100ps
`include "vec_cfg.svh"

module vec_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  vec_pkg::vinsn_t vinsn_i,
  input  logic            start_i,
  output logic            done_o,
  output vec_pkg::elen_t  rdata_o
);

  import vec_pkg::*;

  localparam int unsigned NR_LANES  = `VEC_NR_LANES;
  localparam int unsigned NR_VREGS  = `VEC_NR_VREGS;
  localparam int unsigned EPL       = `VEC_ELEMS_PER_LANE;
  localparam int unsigned SLOT_W    = (EPL > 1) ? $clog2(EPL) : 1;
  localparam int unsigned IDX_W     = $clog2(`VEC_VLMAX);
  localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(EPL - 1);

  elen_t             vrf_q [NR_VREGS][EPL];
  vinsn_t            insn_q;
  logic              busy_q;
  logic              done_q;
  logic [SLOT_W-1:0] slot_q;
  elen_t             rdata_q;
  vl_t               elem_idx;
  elen_t             op_a;
  elen_t             op_b;
  elen_t             alu_res;
  logic              wr_en;
  logic [IDX_W-1:0]  read_idx;
  logic [SLOT_W-1:0] read_slot;
  logic              read_owned;

  assign done_o  = done_q;
  assign rdata_o = rdata_q;

  ////////////////////////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////////////////////////

  // Element i sits in lane i mod NR_LANES at slot i / NR_LANES
  assign elem_idx = vl_t'(slot_q * NR_LANES + LANE_ID);

  always_comb begin
    op_a = vrf_q[insn_q.vs1][slot_q];
    op_b = vrf_q[insn_q.vs2][slot_q];
    case (insn_q.op)
      VADD_VV: alu_res = op_a + op_b;
      VSUB_VV: alu_res = op_a - op_b;
      VAND_VV: alu_res = op_a & op_b;
      VOR_VV:  alu_res = op_a | op_b;
      VXOR_VV: alu_res = op_a ^ op_b;
      VADD_VX: alu_res = op_a + insn_q.scalar;
      VMV_VX:  alu_res = insn_q.scalar;
      VID:     alu_res = elen_t'(elem_idx);
      default: alu_res = op_a;
    endcase
  end

  // Tail elements beyond vl are left as they are
  assign wr_en = busy_q && (insn_q.op != VREAD) && (elem_idx < insn_q.vl);

  // Element read back for VREAD
  assign read_idx   = insn_q.scalar[IDX_W-1:0];
  assign read_slot  = SLOT_W'(read_idx / NR_LANES);
  assign read_owned = ((read_idx % NR_LANES) == LANE_ID);

  ////////////////////////////////////////////////////////////
  // Control and storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      slot_q <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      slot_q <= '0;
    end else if (busy_q) begin
      if (insn_q.op == VREAD || slot_q == LAST_SLOT) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      slot_q <= slot_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) insn_q <= vinsn_i;
    if (busy_q && insn_q.op == VREAD) begin
      rdata_q <= read_owned ? vrf_q[insn_q.vs1][read_slot] : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int r = 0; r < NR_VREGS; r++) begin
        for (int s = 0; s < EPL; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else if (wr_en) begin
      vrf_q[insn_q.vd][slot_q] <= alu_res;
    end
  end

  // Sequencer only starts lanes that have finished
  a_start_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    start_i |-> !busy_q);

endmodule

// File: hdl/vec_sequencer.sv
// Sequencer FSM issuing one instruction to all lanes and forming the response
`timescale 1ns/100ps
`include "vec_cfg.svh"

module vec_sequencer (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  vec_pkg::vinsn_t                       vinsn_i,
  input  logic                                  vinsn_valid_i,
  output logic                                  vinsn_ready_o,
  output vec_pkg::vinsn_t                       lane_vinsn_o,
  output logic                                  lane_start_o,
  input  logic            [`VEC_NR_LANES-1:0]   lane_done_i,
  input  vec_pkg::elen_t  [`VEC_NR_LANES-1:0]   lane_rdata_i,
  output vec_pkg::acc_resp_t                    resp_o,
  output logic                                  resp_valid_o,
  input  logic                                  resp_ready_i
);

  import vec_pkg::*;

  localparam int unsigned NR_LANES = `VEC_NR_LANES;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_BUSY,
    SEQ_RESPOND
  } seq_state_e;

  seq_state_e state_q;
  seq_state_e state_d;
  vinsn_t     held_q;
  elen_t      rdata_or;
  logic       accept;

  ////////////////////////////////////////////////////////////
  // Issue and FSM
  ////////////////////////////////////////////////////////////

  assign vinsn_ready_o = (state_q == SEQ_IDLE);
  assign accept        = vinsn_valid_i & vinsn_ready_o;

  // Lanes latch the broadcast on the start pulse
  assign lane_vinsn_o = vinsn_i;
  assign lane_start_o = accept & ~vinsn_i.illegal;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE: begin
        if (accept) state_d = vinsn_i.illegal ? SEQ_RESPOND : SEQ_BUSY;
      end
      SEQ_BUSY: begin
        if (&lane_done_i) state_d = SEQ_RESPOND;
      end
      SEQ_RESPOND: begin
        if (resp_ready_i) state_d = SEQ_IDLE;
      end
      default: state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) state_q <= SEQ_IDLE;
    else         state_q <= state_d;
  end

  always_ff @(posedge clk_i) begin
    if (accept) held_q <= vinsn_i;
  end

  ////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////

  // Non-owning lanes drive zero, so an OR picks the element
  always_comb begin
    rdata_or = '0;
    for (int l = 0; l < NR_LANES; l++) begin
      rdata_or = rdata_or | lane_rdata_i[l];
    end
  end

  assign resp_valid_o  = (state_q == SEQ_RESPOND);
  assign resp_o.error  = held_q.illegal;
  assign resp_o.result = (!held_q.illegal && held_q.op == VREAD) ? rdata_or : '0;

  // Lanes started together finish together
  a_lanes_done_together: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == SEQ_BUSY) && (|lane_done_i) |-> (&lane_done_i));

endmodule

// File: hdl/vec_dispatcher.sv
// Request decoder mapping raw opcodes to vector instructions and flagging illegal ones
`timescale 1ns/100ps
`include "vec_cfg.svh"

module vec_dispatcher (
  input  vec_pkg::acc_req_t acc_req_i,
  input  logic              acc_req_valid_i,
  output logic              acc_req_ready_o,
  output vec_pkg::vinsn_t   vinsn_o,
  output logic              vinsn_valid_o,
  input  logic              vinsn_ready_i
);

  import vec_pkg::*;

  logic op_known;
  logic vl_too_long;
  logic idx_out_of_range;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Purely combinational stage, no cycles spent here
  assign vinsn_valid_o   = acc_req_valid_i;
  assign acc_req_ready_o = vinsn_ready_i;

  ////////////////////////////////////////////////////////////
  // Legality checks
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (acc_req_i.op)
      VADD_VV,
      VSUB_VV,
      VAND_VV,
      VOR_VV,
      VXOR_VV,
      VADD_VX,
      VMV_VX,
      VID,
      VREAD:   op_known = 1'b1;
      default: op_known = 1'b0;
    endcase
  end

  assign vl_too_long = (acc_req_i.vl > vl_t'(`VEC_VLMAX));

  // Full scalar is compared, not just the index bits
  assign idx_out_of_range = (acc_req_i.op == VREAD) &&
                            (acc_req_i.scalar >= elen_t'(`VEC_VLMAX));

  ////////////////////////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Unknown opcodes carry a harmless op, they never reach the lanes
    vinsn_o.op      = op_known ? vec_op_e'(acc_req_i.op) : VADD_VV;
    vinsn_o.vd      = acc_req_i.vd;
    vinsn_o.vs1     = acc_req_i.vs1;
    vinsn_o.vs2     = acc_req_i.vs2;
    vinsn_o.vl      = acc_req_i.vl;
    vinsn_o.scalar  = acc_req_i.scalar;
    vinsn_o.illegal = !op_known || vl_too_long || idx_out_of_range;
  end

endmodule

// File: hdl/vec_skid_buffer.sv
// Two-entry valid/ready skid buffer with a type-parameterized payload
`timescale 1ns/100ps

module vec_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  payload_t in_data_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_data_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  payload_t   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // Accept while a slot is free, present the oldest entry
  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop)  rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

  // A stalled output keeps its entry until it is taken
  a_out_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

// File: hdl/vec_pkg.sv
// Package with opcode enum, element types, request, instruction and response structs
`include "vec_cfg.svh"

package vec_pkg;

  ////////////////////////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////////////////////////

  typedef logic [`VEC_ELEN-1:0]              elen_t;
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0]  vreg_idx_t;
  // One extra bit so that vl can reach VLMAX itself
  typedef logic [$clog2(`VEC_VLMAX):0]       vl_t;

  // Raw opcode encodings seen on the request port
  typedef enum logic [3:0] {
    VADD_VV = 4'd0,
    VSUB_VV = 4'd1,
    VAND_VV = 4'd2,
    VOR_VV  = 4'd3,
    VXOR_VV = 4'd4,
    VADD_VX = 4'd5,
    VMV_VX  = 4'd6,
    VID     = 4'd7,
    VREAD   = 4'd8
  } vec_op_e;

  ////////////////////////////////////////////////////////////
  // Interface structs
  ////////////////////////////////////////////////////////////

  // Request from the scalar core
  typedef struct packed {
    logic [3:0] op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    vl_t        vl;
    elen_t      scalar;
  } acc_req_t;

  // Decoded instruction, broadcast to the lanes
  typedef struct packed {
    vec_op_e    op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    vl_t        vl;
    elen_t      scalar;
    logic       illegal;
  } vinsn_t;

  // Response back to the core
  typedef struct packed {
    elen_t      result;
    logic       error;
  } acc_resp_t;

endpackage

// File: hdl/vec_cfg.svh
// Configuration macros for lane count, element width, register count and vector length
`ifndef VEC_CFG_SVH
`define VEC_CFG_SVH

// Number of parallel lanes, a power of two
`define VEC_NR_LANES 4

// Element width in bits
`define VEC_ELEN 32

// Architectural vector registers
`define VEC_NR_VREGS 8

// Maximum vector length in elements
`define VEC_VLMAX 16

// Elements of one register held by each lane
`define VEC_ELEMS_PER_LANE (`VEC_VLMAX / `VEC_NR_LANES)

`endif
